/* verilog/mxu_params.svh */
/*
  Matrix-vector engine sizes and depths
*/
`ifndef MXU_PARAMS_SVH
`define MXU_PARAMS_SVH

`default_nettype none

// Output lanes and inner elements per tile
`define MXU_N 4
`define MXU_M 4
`define MXU_MAX_TILES 8

// Must be a power of two
`define MXU_FIFO_DEPTH 4
`define MXU_ACC_W 32

`default_nettype wire

`endif

/* verilog/mxu_pkg.sv */
/*
  Matrix-vector engine shared types
*/
`include "mxu_params.svh"
`default_nettype none

package mxu_pkg;

  typedef logic signed [7:0] elem_t;
  typedef elem_t [`MXU_M-1:0] inp_t;
  // Row n feeds lane n
  typedef inp_t [`MXU_N-1:0] weight_t;

  typedef logic signed [`MXU_ACC_W-1:0] acc_t;
  typedef acc_t [`MXU_N-1:0] bias_t;
  typedef elem_t [`MXU_N-1:0] oup_t;

  typedef logic [$clog2(`MXU_MAX_TILES+1)-1:0] tiles_t;
  typedef logic [$clog2(`MXU_FIFO_DEPTH):0] usage_t;

  typedef logic [7:0] requant_mult_t;
  typedef logic [4:0] requant_shift_t;

endpackage

`default_nettype wire

/* verilog/mxu_controller.sv */
/*
  Matrix-vector engine controller: accepts tile beats, tracks inner tiles
  and holds back new jobs until the output FIFO has room
*/
`timescale 1ns/1ps
`include "mxu_params.svh"
`default_nettype none

module mxu_controller (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            inp_valid_i,
  output logic            inp_ready_o,
  input  logic            bias_valid_i,
  output logic            bias_ready_o,
  input  logic            tile_valid_i,
  input  mxu_pkg::tiles_t ctrl_tiles_i,
  input  mxu_pkg::usage_t fifo_usage_i,
  output logic            calc_en_o,
  output logic            first_o,
  output logic            last_o,
  output logic            busy_o
);

  import mxu_pkg::*;

  // Cycles from beat accept to FIFO push
  localparam int unsigned PipeDepth = 4;

  tiles_t                 tile_q;
  usage_t                 inflight_q;
  logic [PipeDepth-1:0]   pend_q;
  logic                   credit_ok;
  logic                   job_done;

  assign first_o = (tile_q == '0);
  assign last_o  = (tile_q == tiles_t'(ctrl_tiles_i - 1'b1));

  assign credit_ok = ({1'b0, inflight_q} + {1'b0, fifo_usage_i}) < `MXU_FIFO_DEPTH;

  // Bias travels with the first beat of a job
  assign inp_ready_o  = tile_valid_i & (!first_o | (bias_valid_i & credit_ok));
  assign bias_ready_o = first_o & tile_valid_i & credit_ok & inp_valid_i;
  assign calc_en_o    = inp_valid_i & inp_ready_o;

  assign job_done = calc_en_o & last_o;
  assign busy_o   = (tile_q != '0) | (inflight_q != '0);

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      tile_q <= '0;
    end else if (calc_en_o) begin
      tile_q <= last_o ? '0 : tile_q + 1'b1;
    end
  end

  // Results not yet visible in the FIFO usage
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      pend_q     <= '0;
      inflight_q <= '0;
    end else begin
      pend_q     <= {pend_q[PipeDepth-2:0], job_done};
      inflight_q <= inflight_q + usage_t'(job_done) - usage_t'(pend_q[PipeDepth-1]);
    end
  end

  a_credit_bound : assert property (@(posedge clk_i) disable iff (!rst_ni)
    ({1'b0, inflight_q} + {1'b0, fifo_usage_i}) <= `MXU_FIFO_DEPTH);

  a_tiles_nonzero : assert property (@(posedge clk_i) disable iff (!rst_ni)
    busy_o |-> ctrl_tiles_i != '0);

endmodule

`default_nettype wire

/* verilog/mxu_weight_buffer.sv */
/*
  Two-entry ping-pong weight tile store
*/
`timescale 1ns/1ps
`default_nettype none

module mxu_weight_buffer (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             weight_valid_i,
  output logic             weight_ready_o,
  input  mxu_pkg::weight_t weight_i,
  input  logic             tile_pop_i,
  output logic             tile_valid_o,
  output mxu_pkg::weight_t tile_o
);

  import mxu_pkg::*;

  weight_t    mem_q [2];
  logic       wr_ptr_q, rd_ptr_q;
  logic [1:0] cnt_q;
  logic       push;

  // A full buffer still takes a tile while one leaves
  assign weight_ready_o = (cnt_q != 2'd2) | tile_pop_i;
  assign push           = weight_valid_i & weight_ready_o;
  assign tile_valid_o   = (cnt_q != 2'd0);
  assign tile_o         = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= weight_i;
    end
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      cnt_q    <= 2'd0;
    end else begin
      if (push) wr_ptr_q <= ~wr_ptr_q;
      if (tile_pop_i) rd_ptr_q <= ~rd_ptr_q;
      cnt_q <= cnt_q + 2'(push) - 2'(tile_pop_i);
    end
  end

  a_no_pop_empty : assert property (@(posedge clk_i) disable iff (!rst_ni)
    tile_pop_i |-> tile_valid_o);

endmodule

`default_nettype wire

/* verilog/mxu_dotp_acc.sv */
/*
  Lane dot products and bias-seeded accumulator, two register stages
*/
`timescale 1ns/1ps
`include "mxu_params.svh"
`default_nettype none

module mxu_dotp_acc (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             calc_en_i,
  input  logic             first_i,
  input  logic             last_i,
  input  mxu_pkg::inp_t    inp_i,
  input  mxu_pkg::weight_t weight_i,
  input  mxu_pkg::bias_t   bias_i,
  output mxu_pkg::bias_t   result_o,
  output logic             result_valid_o
);

  import mxu_pkg::*;

  bias_t prod_q, bias_q, acc_q;
  logic  en_q, first_q, last_q;
  logic  result_valid_q;

  function automatic acc_t lane_sum(inp_t a, inp_t w);
    acc_t s;
    s = '0;
    for (int m = 0; m < `MXU_M; m++) begin
      s += acc_t'(a[m]) * acc_t'(w[m]);
    end
    return s;
  endfunction

  // Stage one
  always_ff @(posedge clk_i) begin
    if (calc_en_i) begin
      for (int n = 0; n < `MXU_N; n++) begin
        prod_q[n] <= lane_sum(inp_i, weight_i[n]);
      end
      if (first_i) bias_q <= bias_i;
    end
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      en_q    <= 1'b0;
      first_q <= 1'b0;
      last_q  <= 1'b0;
    end else begin
      en_q    <= calc_en_i;
      first_q <= first_i;
      last_q  <= last_i;
    end
  end

  // Stage two, first tile starts from the bias
  always_ff @(posedge clk_i) begin
    if (en_q) begin
      for (int n = 0; n < `MXU_N; n++) begin
        acc_q[n] <= (first_q ? bias_q[n] : acc_q[n]) + prod_q[n];
      end
    end
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      result_valid_q <= 1'b0;
    end else begin
      result_valid_q <= en_q & last_q;
    end
  end

  assign result_o       = acc_q;
  assign result_valid_o = result_valid_q;

endmodule

`default_nettype wire

/* verilog/mxu_requantizer.sv */
/*
  Requantizer: multiply, arithmetic shift, add and saturate to int8 per lane
*/
`timescale 1ns/1ps
`include "mxu_params.svh"
`default_nettype none

module mxu_requantizer (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    valid_i,
  input  mxu_pkg::bias_t          acc_i,
  input  mxu_pkg::requant_mult_t  mult_i,
  input  mxu_pkg::requant_shift_t shift_i,
  input  mxu_pkg::elem_t          add_i,
  output mxu_pkg::oup_t           oup_o,
  output logic                    valid_o
);

  import mxu_pkg::*;

  oup_t oup_q;
  logic valid_q;

  function automatic elem_t requant(acc_t acc, requant_mult_t mult,
                                    requant_shift_t shift, elem_t add);
    logic signed [`MXU_ACC_W+8:0] prod;
    logic signed [`MXU_ACC_W+9:0] sum;
    prod = acc * $signed({1'b0, mult});
    // Floor rounding from the arithmetic shift
    sum = (prod >>> shift) + add;
    if (sum > 127) return 8'sd127;
    if (sum < -128) return -8'sd128;
    return sum[7:0];
  endfunction

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      for (int n = 0; n < `MXU_N; n++) begin
        oup_q[n] <= requant(acc_i[n], mult_i, shift_i, add_i);
      end
    end
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_i;
    end
  end

  assign oup_o   = oup_q;
  assign valid_o = valid_q;

endmodule

`default_nettype wire

/* verilog/mxu_fifo.sv */
/*
  Output FIFO, circular buffer without fall-through, with usage count
*/
`timescale 1ns/1ps
`include "mxu_params.svh"
`default_nettype none

module mxu_fifo #(
  parameter int unsigned DEPTH = `MXU_FIFO_DEPTH
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            push_i,
  input  mxu_pkg::oup_t   data_i,
  input  logic            pop_i,
  output mxu_pkg::oup_t   data_o,
  output logic            empty_o,
  output logic            full_o,
  output mxu_pkg::usage_t usage_o
);

  import mxu_pkg::*;

  localparam int unsigned AddrW = $clog2(DEPTH);

  oup_t             mem_q [DEPTH];
  logic [AddrW-1:0] wr_ptr_q, rd_ptr_q;
  logic [AddrW:0]   cnt_q;

  assign empty_o = (cnt_q == '0);
  assign full_o  = (cnt_q == DEPTH);
  assign usage_o = usage_t'(cnt_q);
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // Pointers wrap on their own for power-of-two depths
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop_i) rd_ptr_q <= rd_ptr_q + 1'b1;
      cnt_q <= cnt_q + (AddrW+1)'(push_i) - (AddrW+1)'(pop_i);
    end
  end

  a_no_overflow : assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i && full_o |-> pop_i);

  a_no_underflow : assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> !empty_o);

endmodule

`default_nettype wire

/* verilog/mxu_top.sv */
/*
  Integer matrix-vector engine top level
  Tile beats through dot products, accumulation and requantization to the FIFO
*/
`timescale 1ns/1ps
`include "mxu_params.svh"
`default_nettype none

module mxu_top (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    inp_valid_i,
  output logic                    inp_ready_o,
  input  mxu_pkg::inp_t           inp_i,
  input  logic                    weight_valid_i,
  output logic                    weight_ready_o,
  input  mxu_pkg::weight_t        weight_i,
  input  logic                    bias_valid_i,
  output logic                    bias_ready_o,
  input  mxu_pkg::bias_t          bias_i,
  input  mxu_pkg::tiles_t         ctrl_tiles_i,
  input  mxu_pkg::requant_mult_t  ctrl_mult_i,
  input  mxu_pkg::requant_shift_t ctrl_shift_i,
  input  mxu_pkg::elem_t          ctrl_add_i,
  output logic                    valid_o,
  input  logic                    ready_i,
  output mxu_pkg::oup_t           oup_o,
  output logic                    busy_o
);

  import mxu_pkg::*;

  logic    calc_en, first, last, tile_valid;
  logic    calc_en_q, first_q, last_q;
  weight_t tile, tile_q;
  inp_t    inp_q;
  bias_t   bias_q, acc;
  logic    acc_valid;
  oup_t    requant_oup;
  logic    push, pop, fifo_empty;
  usage_t  fifo_usage;

  // Operand stage, the weight tile leaves the buffer on accept
  always_ff @(posedge clk_i) begin
    if (calc_en) begin
      inp_q  <= inp_i;
      tile_q <= tile;
      if (first) bias_q <= bias_i;
    end
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      calc_en_q <= 1'b0;
      first_q   <= 1'b0;
      last_q    <= 1'b0;
    end else begin
      calc_en_q <= calc_en;
      first_q   <= first;
      last_q    <= last;
    end
  end

  mxu_controller i_controller (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .inp_valid_i (inp_valid_i),
    .inp_ready_o (inp_ready_o),
    .bias_valid_i(bias_valid_i),
    .bias_ready_o(bias_ready_o),
    .tile_valid_i(tile_valid),
    .ctrl_tiles_i(ctrl_tiles_i),
    .fifo_usage_i(fifo_usage),
    .calc_en_o   (calc_en),
    .first_o     (first),
    .last_o      (last),
    .busy_o      (busy_o)
  );

  mxu_weight_buffer i_weight_buffer (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .weight_valid_i(weight_valid_i),
    .weight_ready_o(weight_ready_o),
    .weight_i      (weight_i),
    .tile_pop_i    (calc_en),
    .tile_valid_o  (tile_valid),
    .tile_o        (tile)
  );

  mxu_dotp_acc i_dotp_acc (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .calc_en_i     (calc_en_q),
    .first_i       (first_q),
    .last_i        (last_q),
    .inp_i         (inp_q),
    .weight_i      (tile_q),
    .bias_i        (bias_q),
    .result_o      (acc),
    .result_valid_o(acc_valid)
  );

  mxu_requantizer i_requantizer (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .valid_i(acc_valid),
    .acc_i  (acc),
    .mult_i (ctrl_mult_i),
    .shift_i(ctrl_shift_i),
    .add_i  (ctrl_add_i),
    .oup_o  (requant_oup),
    .valid_o(push)
  );

  mxu_fifo #(
    .DEPTH(`MXU_FIFO_DEPTH)
  ) i_fifo (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .push_i (push),
    .data_i (requant_oup),
    .pop_i  (pop),
    .data_o (oup_o),
    .empty_o(fifo_empty),
    .full_o (),
    .usage_o(fifo_usage)
  );

  assign valid_o = !fifo_empty;
  assign pop     = valid_o & ready_i;

endmodule

`default_nettype wire

/* bench/tb_mxu.sv */
/*
  Matrix-vector engine testbench: job table against a reference model,
  random output back-pressure and a watchdog
*/
`timescale 1ns/1ps
`include "mxu_params.svh"
`default_nettype none

module tb_mxu;

  import mxu_pkg::*;

  localparam int NJobs     = 7;
  localparam int NTiles    = 18;
  localparam int TimeoutNs = (40 * NTiles + 200) * 4;

  logic           clk_i;
  logic           rst_ni;
  logic           inp_valid_i;
  logic           inp_ready_o;
  inp_t           inp_i;
  logic           weight_valid_i;
  logic           weight_ready_o;
  weight_t        weight_i;
  logic           bias_valid_i;
  logic           bias_ready_o;
  bias_t          bias_i;
  tiles_t         ctrl_tiles_i;
  requant_mult_t  ctrl_mult_i;
  requant_shift_t ctrl_shift_i;
  elem_t          ctrl_add_i;
  logic           valid_o;
  logic           ready_i;
  oup_t           oup_o;
  logic           busy_o;

  // Job table
  string          job_name [NJobs];
  int             job_tiles [NJobs];
  int             job_start [NJobs];
  requant_mult_t  job_mult [NJobs];
  requant_shift_t job_shift [NJobs];
  elem_t          job_add [NJobs];
  bias_t          job_bias [NJobs];
  oup_t           job_exp [NJobs];
  inp_t           tile_inp [NTiles];
  weight_t        tile_w [NTiles];

  oup_t        exp_q [$];
  string       name_q [$];
  logic [15:0] lfsr_q = 16'd79;
  int          errors = 0;
  int          out_cnt = 0;
  int          w_sent = 0;
  int          job_cnt = 0;
  int          tile_cnt = 0;

  mxu_top dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // x^16 + x^14 + x^13 + x^11
  function automatic logic [15:0] lfsr_step(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [15:0] rand_bits(int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v      = {v[14:0], lfsr_q[15]};
      lfsr_q = lfsr_step(lfsr_q);
    end
    return v;
  endfunction

  task automatic add_job(string name, int tiles, requant_mult_t mult,
                         requant_shift_t shift, elem_t add);
    job_name[job_cnt]  = name;
    job_tiles[job_cnt] = tiles;
    job_start[job_cnt] = tile_cnt;
    job_mult[job_cnt]  = mult;
    job_shift[job_cnt] = shift;
    job_add[job_cnt]   = add;
    for (int n = 0; n < `MXU_N; n++) begin
      job_bias[job_cnt][n] = acc_t'($signed(rand_bits(16)));
    end
    for (int t = 0; t < tiles; t++) begin
      for (int m = 0; m < `MXU_M; m++) begin
        tile_inp[tile_cnt][m] = elem_t'(rand_bits(8));
        for (int n = 0; n < `MXU_N; n++) begin
          tile_w[tile_cnt][n][m] = elem_t'(rand_bits(8));
        end
      end
      tile_cnt++;
    end
    job_cnt++;
  endtask

  // Lanes 0 and 1 clamp high and low, lanes 2 and 3 stay in range
  task automatic make_saturating(int j);
    int s;
    s = job_start[j];
    for (int m = 0; m < `MXU_M; m++) begin
      tile_inp[s][m]  = 8'sd127;
      tile_w[s][0][m] = 8'sd127;
      tile_w[s][1][m] = -8'sd128;
      tile_w[s][2][m] = 8'sd1;
      tile_w[s][3][m] = -8'sd1;
    end
    job_bias[j]    = '0;
    job_bias[j][2] = 17;
    job_bias[j][3] = -40;
  endtask

  // Bias plus all tile dot products, then multiply, floor shift, add, clamp
  function automatic oup_t expected_result(int j);
    longint acc;
    longint v;
    int     s;
    oup_t   r;
    for (int n = 0; n < `MXU_N; n++) begin
      acc = longint'(job_bias[j][n]);
      for (int t = 0; t < job_tiles[j]; t++) begin
        s = job_start[j] + t;
        for (int m = 0; m < `MXU_M; m++) begin
          acc += longint'(tile_inp[s][m]) * longint'(tile_w[s][n][m]);
        end
      end
      v = (acc * longint'(job_mult[j])) >>> job_shift[j];
      v = v + longint'(job_add[j]);
      if (v > 127) v = 127;
      if (v < -128) v = -128;
      r[n] = elem_t'(v);
    end
    return r;
  endfunction

  function automatic bit same_settings(int a, int b);
    return job_tiles[a] == job_tiles[b] && job_mult[a] == job_mult[b] &&
           job_shift[a] == job_shift[b] && job_add[a] == job_add[b];
  endfunction

  task automatic drive_weights();
    logic accepted;
    for (int t = 0; t < NTiles; t++) begin
      @(negedge clk_i);
      weight_valid_i = 1'b1;
      weight_i       = tile_w[t];
      #1;
      accepted = weight_ready_o;
      @(posedge clk_i);
      while (!accepted) begin
        @(negedge clk_i);
        #1;
        accepted = weight_ready_o;
        @(posedge clk_i);
      end
      w_sent++;
    end
    @(negedge clk_i);
    weight_valid_i = 1'b0;
  endtask

  // Bias is taken exactly with the first beat of a job
  task automatic compare_bias_ready(string name, logic exp);
    if (bias_ready_o !== exp) begin
      $display("[ERROR] %s bias_ready_o: expected %b, got %b", name, exp, bias_ready_o);
      errors++;
    end
  endtask

  task automatic drive_inputs();
    logic accepted;
    // Weights run ahead until the ping-pong buffer is full
    repeat (10) @(negedge clk_i);
    #1;
    if (weight_ready_o !== 1'b0 || w_sent != 2) begin
      $display("[ERROR] weights_ahead: expected 2 tiles and ready 0, got %0d tiles and ready %b",
               w_sent, weight_ready_o);
      errors++;
    end
    for (int j = 0; j < NJobs; j++) begin
      // Requantizer settings are levels, so a change waits for the engine to drain
      if (j > 0 && !same_settings(j, j - 1)) begin
        @(negedge clk_i);
        inp_valid_i  = 1'b0;
        bias_valid_i = 1'b0;
        #1;
        while (busy_o) begin
          @(negedge clk_i);
          #1;
        end
      end
      for (int t = 0; t < job_tiles[j]; t++) begin
        @(negedge clk_i);
        ctrl_tiles_i = tiles_t'(job_tiles[j]);
        ctrl_mult_i  = job_mult[j];
        ctrl_shift_i = job_shift[j];
        ctrl_add_i   = job_add[j];
        inp_valid_i  = 1'b1;
        inp_i        = tile_inp[job_start[j] + t];
        bias_valid_i = (t == 0);
        bias_i       = job_bias[j];
        #1;
        accepted = inp_ready_o;
        compare_bias_ready(job_name[j], (t == 0) && accepted);
        @(posedge clk_i);
        while (!accepted) begin
          @(negedge clk_i);
          #1;
          accepted = inp_ready_o;
          compare_bias_ready(job_name[j], (t == 0) && accepted);
          @(posedge clk_i);
        end
      end
    end
    @(negedge clk_i);
    inp_valid_i  = 1'b0;
    bias_valid_i = 1'b0;
  endtask

  task automatic check_outputs();
    logic held;
    oup_t held_val;
    held = 1'b0;
    forever begin
      @(negedge clk_i);
      ready_i = (rand_bits(2) != 0);
      #1;
      if (held && (valid_o !== 1'b1 || oup_o !== held_val)) begin
        $display("[ERROR] output_hold: expected %h, got %h with valid_o %b",
                 held_val, oup_o, valid_o);
        errors++;
      end
      held     = valid_o && !ready_i;
      held_val = oup_o;
      if (valid_o && ready_i) begin
        if (exp_q.size() == 0) begin
          $display("Output %h arrived after all expected results", oup_o);
          errors++;
        end else begin
          if (oup_o !== exp_q[0]) begin
            $display("[ERROR] %s: expected %h, got %h", name_q[0], exp_q[0], oup_o);
            errors++;
          end
          void'(exp_q.pop_front());
          void'(name_q.pop_front());
        end
        out_cnt++;
      end
    end
  endtask

  initial begin
    #(TimeoutNs);
    $display("Watchdog expired with %0d of %0d results received", out_cnt, NJobs);
    $display("Test failed");
    $finish;
  end

  initial begin
    rst_ni         = 1'b0;
    inp_valid_i    = 1'b0;
    inp_i          = '0;
    weight_valid_i = 1'b0;
    weight_i       = '0;
    bias_valid_i   = 1'b0;
    bias_i         = '0;
    ctrl_tiles_i   = tiles_t'(1);
    ctrl_mult_i    = '0;
    ctrl_shift_i   = '0;
    ctrl_add_i     = '0;
    ready_i        = 1'b0;

    add_job("single_tile", 1, 8'd3, 5'd8, 8'sd5);
    add_job("eight_tiles", 8, 8'd1, 5'd10, -8'sd1);
    add_job("saturate", 1, 8'd2, 5'd4, -8'sd3);
    add_job("back_to_back_0", 2, 8'd5, 5'd9, -8'sd2);
    add_job("back_to_back_1", 2, 8'd5, 5'd9, -8'sd2);
    add_job("back_to_back_2", 2, 8'd5, 5'd9, -8'sd2);
    add_job("back_to_back_3", 2, 8'd5, 5'd9, -8'sd2);
    make_saturating(2);
    for (int j = 0; j < NJobs; j++) begin
      job_exp[j] = expected_result(j);
      exp_q.push_back(job_exp[j]);
      name_q.push_back(job_name[j]);
    end

    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    #1;
    if (valid_o !== 1'b0 || busy_o !== 1'b0 || inp_ready_o !== 1'b0) begin
      $display("Engine not idle after reset: valid_o %b, busy_o %b, inp_ready_o %b",
               valid_o, busy_o, inp_ready_o);
      errors++;
    end

    fork
      drive_weights();
      drive_inputs();
      check_outputs();
    join_none

    while (out_cnt < NJobs) @(negedge clk_i);
    repeat (8) @(negedge clk_i);
    #1;
    if (valid_o !== 1'b0 || busy_o !== 1'b0) begin
      $display("Engine not idle after all jobs drained: valid_o %b, busy_o %b",
               valid_o, busy_o);
      errors++;
    end

    $display("Errors: %0d, results received: %0d of %0d", errors, out_cnt, NJobs);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+verilog
verilog/mxu_pkg.sv
verilog/mxu_controller.sv
verilog/mxu_weight_buffer.sv
verilog/mxu_dotp_acc.sv
verilog/mxu_requantizer.sv
verilog/mxu_fifo.sv
verilog/mxu_top.sv
bench/tb_mxu.sv

/* Makefile */
# Verilator simulation of the matrix-vector engine testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_mxu \
		-f list.f --Mdir obj_dir
	./obj_dir/Vtb_mxu | tee sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
